// ==== rtl/cpu_macros.svh ====
// -------------------------------------------------------------------------
// CPU core constants
// Reset vector location, status reset value and fetch step
// -------------------------------------------------------------------------

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Reset vector, low byte first
`define CPU_RESET_VEC_LO 16'hFFFC
`define CPU_RESET_VEC_HI 16'hFFFD

// Only the always-one bit is set out of reset
`define CPU_STATUS_RESET 8'h20

// Address step from the opcode to its first operand byte
`define CPU_FETCH_OFFSET 16'd1

`endif

// ==== rtl/cpu_core_pkg.sv ====
// -------------------------------------------------------------------------
// Core types: bus widths, sequencer states and ALU operations
// -------------------------------------------------------------------------

package cpu_core_pkg;

  // Data byte, registers and bus data
  typedef logic [7:0]  data_t;
  // Memory address and program counter
  typedef logic [15:0] addr_t;
  // Processor status register
  typedef logic [7:0]  status_t;

  // Instruction cycle states
  typedef enum logic [2:0] {
    RESET,
    VECTOR_LO,
    VECTOR_HI,
    FETCH,
    DECODE,
    ABS_1,
    ABS_2,
    HALT
  } cpu_state_t;

  // ALU operations
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR
  } alu_op_t;

endpackage

// ==== rtl/cpu_isa_pkg.sv ====
// -------------------------------------------------------------------------
// Instruction set definitions for the 6502 subset
// -------------------------------------------------------------------------

package cpu_isa_pkg;

  // Kept opcodes, standard 6502 encodings
  typedef enum logic [7:0] {
    // Implied
    OP_CLC     = 8'h18,
    OP_SEC     = 8'h38,
    OP_CLV     = 8'hB8,
    OP_NOP     = 8'hEA,
    // Immediate
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    // Absolute loads, stores and jump
    OP_LDA_ABS = 8'hAD,
    OP_LDX_ABS = 8'hAE,
    OP_LDY_ABS = 8'hAC,
    OP_STA_ABS = 8'h8D,
    OP_STX_ABS = 8'h8E,
    OP_STY_ABS = 8'h8C,
    OP_JMP_ABS = 8'h4C,
    // Absolute ALU group
    OP_ADC_ABS = 8'h6D,
    OP_SBC_ABS = 8'hED,
    OP_AND_ABS = 8'h2D,
    OP_ORA_ABS = 8'h0D,
    OP_EOR_ABS = 8'h4D,
    OP_CMP_ABS = 8'hCD
  } opcode_t;

  // Status register bit positions
  parameter int FLAG_C   = 0;
  parameter int FLAG_Z   = 1;
  parameter int FLAG_ONE = 5;
  parameter int FLAG_V   = 6;
  parameter int FLAG_N   = 7;

endpackage

// ==== rtl/alu_if.sv ====
// -------------------------------------------------------------------------
// ALU bus between datapath, status register and ALU
// -------------------------------------------------------------------------

`timescale 1ns/1ns

interface alu_if import cpu_core_pkg::*; ();

  alu_op_t op;
  data_t   a;
  data_t   b;
  logic    carry_in;
  data_t   result;
  status_t flags;

  // Operands and result
  modport datapath (output op, a, b, input result);
  // Carry source and flag sink
  modport status (output carry_in, input flags);
  modport alu (input op, a, b, carry_in, output result, flags);

endinterface

// ==== rtl/cpu_alu.sv ====
// -------------------------------------------------------------------------
// 8-bit ALU, add/subtract with carry and bitwise logic, N Z C V flags
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module cpu_alu import cpu_core_pkg::*, cpu_isa_pkg::*; (
  alu_if.alu alu
);

  data_t      b_eff;
  logic [8:0] sum;
  data_t      res;
  logic       arith;

  always_comb begin
    arith = (alu.op == ADD) || (alu.op == SUB);
    // Subtract as a + ~b + c, carry out means no borrow
    b_eff = (alu.op == SUB) ? ~alu.b : alu.b;
    sum   = {1'b0, alu.a} + {1'b0, b_eff} + {8'd0, alu.carry_in};

    case (alu.op)
      AND:     res = alu.a & alu.b;
      OR:      res = alu.a | alu.b;
      XOR:     res = alu.a ^ alu.b;
      default: res = sum[7:0];
    endcase
  end

  assign alu.result = res;

  // Flags, C and V only meaningful for add and subtract
  always_comb begin
    alu.flags         = '0;
    alu.flags[FLAG_N] = res[7];
    alu.flags[FLAG_Z] = (res == 8'h00);
    alu.flags[FLAG_C] = arith & sum[8];
    // Same operand signs, different result sign
    alu.flags[FLAG_V] = arith & (alu.a[7] == b_eff[7]) & (res[7] != alu.a[7]);
  end

endmodule

// ==== rtl/cpu_sequencer.sv ====
// -------------------------------------------------------------------------
// Instruction cycle FSM with addressing-mode decode of the IR
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module cpu_sequencer import cpu_core_pkg::*, cpu_isa_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  opcode_t    ir,
  output cpu_state_t state,
  output logic       halted
);

  cpu_state_t state_next;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= RESET;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      RESET:     state_next = VECTOR_LO;
      VECTOR_LO: state_next = VECTOR_HI;
      VECTOR_HI: state_next = FETCH;
      FETCH:     state_next = DECODE;
      DECODE: begin
        // Addressing mode picks the path
        case (ir)
          OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS,
          OP_STA_ABS, OP_STX_ABS, OP_STY_ABS, OP_JMP_ABS,
          OP_ADC_ABS, OP_SBC_ABS, OP_AND_ABS,
          OP_ORA_ABS, OP_EOR_ABS, OP_CMP_ABS: state_next = ABS_1;
          OP_CLC, OP_SEC, OP_CLV, OP_NOP,
          OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: state_next = FETCH;
          default:                            state_next = HALT;
        endcase
      end
      // JMP is done once the target is known
      ABS_1:     state_next = (ir == OP_JMP_ABS) ? FETCH : ABS_2;
      ABS_2:     state_next = FETCH;
      default:   state_next = HALT;
    endcase
  end

  // Sticky until reset
  assign halted = (state == HALT);

  a_state_known: assert property (@(posedge clk) disable iff (!resetn)
    !$isunknown(state));

endmodule

// ==== rtl/cpu_datapath.sv ====
// -------------------------------------------------------------------------
// Datapath: PC, IR, A/X/Y, low operand byte and memory bus drivers
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cpu_macros.svh"

module cpu_datapath import cpu_core_pkg::*, cpu_isa_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  cpu_state_t state,
  input  data_t      rd_data,
  output opcode_t    ir,
  output addr_t      address,
  output data_t      wr_data,
  output logic       wr_enable,
  alu_if.datapath    alu
);

  addr_t   pc;
  data_t   acc;
  data_t   x_reg;
  data_t   y_reg;
  data_t   op_lo;
  alu_op_t alu_op_q;
  data_t   alu_a_q;
  data_t   alu_b_q;

  assign alu.op = alu_op_q;
  assign alu.a  = alu_a_q;
  assign alu.b  = alu_b_q;

  // -------------------------------------------------------------------------
  // Bus and control registers
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      address   <= `CPU_RESET_VEC_LO;
      wr_enable <= 1'b0;
      ir        <= OP_NOP;
    end else begin
      case (state)
        RESET: address <= `CPU_RESET_VEC_LO;
        VECTOR_LO: begin
          address  <= `CPU_RESET_VEC_HI;
          pc[7:0]  <= rd_data;
        end
        VECTOR_HI: begin
          address  <= {rd_data, pc[7:0]};
          pc[15:8] <= rd_data;
        end
        FETCH: begin
          ir      <= opcode_t'(rd_data);
          address <= pc + `CPU_FETCH_OFFSET;
          // Result of the previous ALU instruction
          if (ir inside {OP_ADC_ABS, OP_SBC_ABS, OP_AND_ABS, OP_ORA_ABS, OP_EOR_ABS}) begin
            acc <= alu.result;
          end
        end
        DECODE: begin
          op_lo <= rd_data;
          case (ir)
            OP_CLC, OP_SEC, OP_CLV, OP_NOP: begin
              address <= pc + 16'd1;
              pc      <= pc + 16'd1;
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
              address <= pc + 16'd2;
              pc      <= pc + 16'd2;
              if (ir == OP_LDA_IMM) acc <= rd_data;
              if (ir == OP_LDX_IMM) x_reg <= rd_data;
              if (ir == OP_LDY_IMM) y_reg <= rd_data;
            end
            // Absolute, fetch the high operand byte
            default: address <= pc + 16'd2;
          endcase
        end
        ABS_1: begin
          address <= {rd_data, op_lo};
          case (ir)
            OP_JMP_ABS: pc <= {rd_data, op_lo};
            OP_STA_ABS, OP_STX_ABS, OP_STY_ABS: begin
              wr_enable <= 1'b1;
              if (ir == OP_STA_ABS) wr_data <= acc;
              if (ir == OP_STX_ABS) wr_data <= x_reg;
              if (ir == OP_STY_ABS) wr_data <= y_reg;
            end
            default: ;
          endcase
        end
        ABS_2: begin
          wr_enable <= 1'b0;
          pc        <= pc + 16'd3;
          address   <= pc + 16'd3;
          // Operands for the ALU, result used at next FETCH
          alu_a_q   <= acc;
          alu_b_q   <= rd_data;
          case (ir)
            OP_LDA_ABS: acc <= rd_data;
            OP_LDX_ABS: x_reg <= rd_data;
            OP_LDY_ABS: y_reg <= rd_data;
            OP_ADC_ABS: alu_op_q <= ADD;
            OP_SBC_ABS, OP_CMP_ABS: alu_op_q <= SUB;
            OP_AND_ABS: alu_op_q <= AND;
            OP_ORA_ABS: alu_op_q <= OR;
            OP_EOR_ABS: alu_op_q <= XOR;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // Store strobe is a single cycle
  a_wr_single: assert property (@(posedge clk) disable iff (!resetn)
    wr_enable |=> !wr_enable);

endmodule

// ==== rtl/cpu_status.sv ====
// -------------------------------------------------------------------------
// Processor status register with per-instruction flag update
// -------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cpu_macros.svh"

module cpu_status import cpu_core_pkg::*, cpu_isa_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  cpu_state_t state,
  input  opcode_t    ir,
  input  data_t      rd_data,
  alu_if.status      alu
);

  status_t p;
  status_t p_next;
  data_t   ld_byte;

  // CMP always subtracts without borrow
  assign alu.carry_in = (ir == OP_CMP_ABS) ? 1'b1 : p[FLAG_C];

  // Loaded byte, immediate in DECODE, absolute in ABS_2
  always_ff @(posedge clk) begin
    if (state == DECODE || state == ABS_2) begin
      ld_byte <= rd_data;
    end
  end

  // -------------------------------------------------------------------------
  // Flag rules, keyed on the instruction just finished
  // -------------------------------------------------------------------------
  always_comb begin
    p_next = p;
    case (ir)
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM,
      OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS: begin
        p_next[FLAG_N] = ld_byte[7];
        p_next[FLAG_Z] = (ld_byte == 8'h00);
      end
      OP_ADC_ABS, OP_SBC_ABS: begin
        p_next[FLAG_N] = alu.flags[FLAG_N];
        p_next[FLAG_Z] = alu.flags[FLAG_Z];
        p_next[FLAG_C] = alu.flags[FLAG_C];
        p_next[FLAG_V] = alu.flags[FLAG_V];
      end
      OP_AND_ABS, OP_ORA_ABS, OP_EOR_ABS: begin
        p_next[FLAG_N] = alu.flags[FLAG_N];
        p_next[FLAG_Z] = alu.flags[FLAG_Z];
      end
      // C set when A >= M
      OP_CMP_ABS: begin
        p_next[FLAG_N] = alu.flags[FLAG_N];
        p_next[FLAG_Z] = alu.flags[FLAG_Z];
        p_next[FLAG_C] = alu.flags[FLAG_C];
      end
      OP_CLC: p_next[FLAG_C] = 1'b0;
      OP_SEC: p_next[FLAG_C] = 1'b1;
      OP_CLV: p_next[FLAG_V] = 1'b0;
      default: ;
    endcase
    p_next[FLAG_ONE] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      p <= `CPU_STATUS_RESET;
    end else if (state == FETCH) begin
      p <= p_next;
    end
  end

endmodule

// ==== rtl/cpu6502_top.sv ====
// -------------------------------------------------------------------------
// 6502 subset core, sequencer, datapath, status and ALU on one memory bus
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module cpu6502_top import cpu_core_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  input  data_t rd_data,
  output addr_t address,
  output data_t wr_data,
  output logic  wr_enable,
  output logic  halted
);

  cpu_state_t           state;
  cpu_isa_pkg::opcode_t ir;

  alu_if alu_bus ();

  cpu_sequencer u_sequencer (
    .clk    (clk),
    .resetn (resetn),
    .ir     (ir),
    .state  (state),
    .halted (halted)
  );

  cpu_datapath u_datapath (
    .clk       (clk),
    .resetn    (resetn),
    .state     (state),
    .rd_data   (rd_data),
    .ir        (ir),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .alu       (alu_bus.datapath)
  );

  cpu_status u_status (
    .clk     (clk),
    .resetn  (resetn),
    .state   (state),
    .ir      (ir),
    .rd_data (rd_data),
    .alu     (alu_bus.status)
  );

  cpu_alu u_alu (
    .alu (alu_bus.alu)
  );

endmodule

// ==== sim/tb_cpu6502.sv ====
// --------------------------------------------------------------------------
// Testbench for the 6502 subset core, runs a table of small programs
// against a 64K memory model and checks the first store of each
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cpu_macros.svh"

module tb_cpu6502 import cpu_core_pkg::*, cpu_isa_pkg::*; ();

  // Program shapes built around the row's first opcode
  typedef enum logic [1:0] {RUN_ALU, RUN_CARRY, RUN_INDEX, RUN_JUMP} run_kind_t;

  typedef struct packed {
    run_kind_t kind;
    opcode_t   pre;
    opcode_t   op;
    data_t     a;
    data_t     m;
    data_t     exp_data;
    addr_t     exp_addr;
  } row_t;

  localparam data_t BAD_OPCODE = 8'h02;

  logic   clk;
  logic   resetn;
  data_t  rd_data;
  addr_t  address;
  data_t  wr_data;
  logic   wr_enable;
  logic   halted;

  data_t  mem [0:65535];
  row_t   rows [$];
  addr_t  load_ptr;
  int     row_idx;
  int     mismatch_count;
  int     fail_count;
  integer seed;

  cpu6502_top dut (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .halted    (halted)
  );

  always #4 clk = ~clk;

  // Memory model, combinational read, write at the edge
  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (wr_enable) begin
      mem[address] <= wr_data;
    end
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s in row %0d: got %h, expected %h", name, row_idx, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s in row %0d: got %h, expected %h", name, row_idx, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s in row %0d: got %h, expected %h", name, row_idx, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Program loader
  // --------------------------------------------------------------------------
  task automatic put_byte(input data_t b);
    mem[load_ptr] = b;
    load_ptr      = load_ptr + 16'd1;
  endtask

  // Opcode plus little-endian absolute operand
  task automatic put_abs(input opcode_t op, input addr_t target);
    put_byte(op);
    put_byte(target[7:0]);
    put_byte(target[15:8]);
  endtask

  task automatic load_program(input row_t r);
    mem[`CPU_RESET_VEC_LO] = 8'h00;
    mem[`CPU_RESET_VEC_HI] = 8'h80;
    // Operand m, and a zero byte for the carry readout
    mem[16'h0200] = r.m;
    mem[16'h0201] = 8'h00;
    load_ptr = 16'h8000;
    put_byte(r.pre);
    put_byte(OP_LDA_IMM);
    put_byte(r.a);
    case (r.kind)
      RUN_ALU: begin
        put_abs(r.op, 16'h0200);
        put_abs(OP_STA_ABS, 16'h0300);
      end
      // C from CMP shows up as 0 + 0 + C
      RUN_CARRY: begin
        put_abs(OP_CMP_ABS, 16'h0200);
        put_byte(OP_LDA_IMM);
        put_byte(8'h00);
        put_abs(OP_ADC_ABS, 16'h0201);
        put_abs(OP_STA_ABS, 16'h0300);
      end
      RUN_INDEX: begin
        if (r.op inside {OP_LDX_IMM, OP_LDY_IMM}) begin
          put_byte(r.op);
          put_byte(r.m);
        end else begin
          put_abs(r.op, 16'h0200);
        end
        put_abs((r.op inside {OP_LDX_IMM, OP_LDX_ABS}) ? OP_STX_ABS : OP_STY_ABS, 16'h0300);
      end
      // Jump over a bad byte to the store, then halt on another
      default: begin
        put_abs(OP_JMP_ABS, load_ptr + 16'd4);
        put_byte(BAD_OPCODE);
        put_abs(OP_STA_ABS, 16'h0300);
        put_byte(BAD_OPCODE);
      end
    endcase
    // Park on a jump to itself
    if (r.kind != RUN_JUMP) put_abs(OP_JMP_ABS, load_ptr);
  endtask

  function automatic row_t make_row(input run_kind_t kind, input opcode_t pre,
                                    input opcode_t op, input data_t a, input data_t m,
                                    input data_t exp_data);
    row_t r;
    r.kind     = kind;
    r.pre      = pre;
    r.op       = op;
    r.a        = a;
    r.m        = m;
    r.exp_data = exp_data;
    r.exp_addr = 16'h0300;
    return r;
  endfunction

  // Expected bytes follow the ALU rules, truncated to 8 bits
  task automatic build_table();
    rows.push_back(make_row(RUN_ALU,   OP_CLC, OP_ADC_ABS, 8'h35, 8'h4A, 8'h7F));
    rows.push_back(make_row(RUN_ALU,   OP_SEC, OP_ADC_ABS, 8'hF0, 8'h20, 8'h11));
    rows.push_back(make_row(RUN_ALU,   OP_SEC, OP_SBC_ABS, 8'h50, 8'h30, 8'h20));
    rows.push_back(make_row(RUN_ALU,   OP_CLC, OP_SBC_ABS, 8'h50, 8'h30, 8'h1F));
    rows.push_back(make_row(RUN_ALU,   OP_SEC, OP_SBC_ABS, 8'h10, 8'h20, 8'hF0));
    rows.push_back(make_row(RUN_ALU,   OP_SEC, OP_AND_ABS, 8'hCA, 8'h6F, 8'h4A));
    rows.push_back(make_row(RUN_ALU,   OP_CLC, OP_ORA_ABS, 8'h81, 8'h14, 8'h95));
    rows.push_back(make_row(RUN_ALU,   OP_SEC, OP_EOR_ABS, 8'hFF, 8'h5A, 8'hA5));
    // CMP leaves A alone
    rows.push_back(make_row(RUN_ALU,   OP_CLC, OP_CMP_ABS, 8'h77, 8'h10, 8'h77));
    rows.push_back(make_row(RUN_CARRY, OP_CLC, OP_CMP_ABS, 8'h40, 8'h40, 8'h01));
    rows.push_back(make_row(RUN_CARRY, OP_SEC, OP_CMP_ABS, 8'h3F, 8'h40, 8'h00));
    rows.push_back(make_row(RUN_CARRY, OP_CLC, OP_CMP_ABS, 8'h80, 8'h7F, 8'h01));
    rows.push_back(make_row(RUN_INDEX, OP_CLC, OP_LDX_IMM, 8'h11, 8'h5C, 8'h5C));
    rows.push_back(make_row(RUN_INDEX, OP_SEC, OP_LDX_ABS, 8'h22, 8'hA7, 8'hA7));
    rows.push_back(make_row(RUN_INDEX, OP_CLC, OP_LDY_IMM, 8'h33, 8'h00, 8'h00));
    rows.push_back(make_row(RUN_INDEX, OP_SEC, OP_LDY_ABS, 8'h44, 8'hE1, 8'hE1));
    rows.push_back(make_row(RUN_JUMP,  OP_CLC, OP_JMP_ABS, 8'h99, 8'h00, 8'h99));
  endtask

  // --------------------------------------------------------------------------
  // Reset and waits
  // --------------------------------------------------------------------------
  task automatic apply_reset(input row_t r);
    @(posedge clk);
    resetn <= 1'b0;
    @(negedge clk);
    load_program(r);
    repeat (5) @(posedge clk);
    resetn <= 1'b1;
  endtask

  task automatic wait_write(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 100) begin
      @(negedge clk);
      seen = (wr_enable === 1'b1);
      n++;
    end
  endtask

  task automatic wait_halt(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 100) begin
      @(negedge clk);
      seen = (halted === 1'b1);
      n++;
    end
  endtask

  initial begin
    row_t r;
    logic seen;
    clk            = 1'b0;
    resetn         = 1'b0;
    mismatch_count = 0;
    fail_count     = 0;
    seed           = 32'h9572_78d5;
    for (int i = 0; i < 65536; i++) mem[i] = data_t'($random(seed));
    build_table();

    for (int i = 0; i < rows.size(); i++) begin
      r       = rows[i];
      row_idx = i;
      apply_reset(r);
      wait_write(seen);
      if (!seen) begin
        fail_count++;
        $display("Row %0d: no memory write within 100 cycles", row_idx);
      end else begin
        check_addr("address", address, r.exp_addr);
        check_data("wr_data", wr_data, r.exp_data);
        // Strobe lasts one cycle, memory holds the byte
        @(negedge clk);
        check_flag("wr_enable", wr_enable, 1'b0);
        check_data("mem_0300", mem[16'h0300], r.exp_data);
        if (r.kind == RUN_JUMP) begin
          wait_halt(seen);
          if (!seen) begin
            fail_count++;
            $display("Row %0d: core did not halt on the bad opcode", row_idx);
          end
          for (int n = 0; n < 100; n++) begin
            @(negedge clk);
            check_flag("wr_enable", wr_enable, 1'b0);
          end
        end else begin
          check_flag("halted", halted, 1'b0);
        end
      end
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== cpu6502_top.f ====
+incdir+rtl
rtl/cpu_core_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/alu_if.sv
rtl/cpu_alu.sv
rtl/cpu_sequencer.sv
rtl/cpu_datapath.sv
rtl/cpu_status.sv
rtl/cpu6502_top.sv
sim/tb_cpu6502.sv

// ==== Bender.yml ====
package:
  name: cpu6502_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_core_pkg.sv
      - rtl/cpu_isa_pkg.sv
      - rtl/alu_if.sv
      - rtl/cpu_alu.sv
      - rtl/cpu_sequencer.sv
      - rtl/cpu_datapath.sv
      - rtl/cpu_status.sv
      - rtl/cpu6502_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_cpu6502.sv
